// ==== Bender.yml ====
package:
  name: brisc_fetch

sources:
  - src/brisc_pkg.sv
  - src/fetch_stage.sv
  - src/icache.sv
  - src/mem_arbiter.sv
  - src/fetch_top.sv
  - target: test
    files:
      - testbench/fetch_tb.sv

// ==== src/brisc_pkg.sv ====
package brisc_pkg;

  // Byte address on the fetch and memory side
  typedef logic [31:0] addr_t;

  // One memory word as it travels on the memory port
  typedef logic [31:0] word_t;

  // Instruction word handed to the pipeline
  typedef logic [31:0] instr_t;

  // Next-PC source from the execute stage
  typedef enum logic {
    PC_SEQ = 1'b0,  // Sequential or predicted PC
    PC_ALU = 1'b1   // Redirect to pc_target
  } pc_src_e;

  localparam addr_t PC_BOOT = 32'h0000_0000;
  localparam addr_t PC_XCPT = 32'h0000_0100;

  // Line refill sequencer of the instruction cache
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    REQ  = 2'd1,  // Word request held until ic_done
    WAIT = 2'd2   // One free cycle on the port between words
  } icache_state_e;

endpackage

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage (
  input  logic               clk,
  input  logic               reset,
  input  logic               stall,
  input  brisc_pkg::pc_src_e pc_src,
  input  logic               xcpt,
  input  brisc_pkg::addr_t   pc_target,
  input  brisc_pkg::addr_t   branch_pc,
  input  logic               pred_wrong,
  input  logic               hit,
  input  brisc_pkg::instr_t  hit_instr,
  output brisc_pkg::addr_t   lookup_addr,
  output brisc_pkg::instr_t  instr,
  output brisc_pkg::addr_t   pc,
  output brisc_pkg::addr_t   pc_plus4,
  output logic               instr_valid,
  output logic               pred_taken
);

  brisc_pkg::addr_t pc_next;
  logic             redirect;
  logic             pc_en;
  logic             btb_en;

  // One-entry BTB
  brisc_pkg::addr_t btb_pc;
  brisc_pkg::addr_t btb_target;
  logic             btb_valid;

  assign lookup_addr = pc;
  assign instr       = hit_instr;
  assign instr_valid = hit;
  assign pc_plus4    = pc + 32'd4;

  assign redirect   = (pc_src == brisc_pkg::PC_ALU);
  assign pred_taken = btb_valid && (btb_pc == pc) && hit;  // Only on a delivered instruction

  // Exception and redirect move the PC even while stalled or missing
  assign pc_en  = xcpt | redirect | (hit & ~stall);
  assign btb_en = redirect | ~stall;

  always_comb begin
    if (xcpt) begin
      pc_next = brisc_pkg::PC_XCPT;
    end else if (redirect) begin
      pc_next = pc_target;
    end else if (pred_taken) begin
      pc_next = btb_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= brisc_pkg::PC_BOOT;
    end else if (pc_en) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      btb_valid <= 1'b0;
    end else if (btb_en) begin
      if (pred_wrong) begin
        btb_valid <= 1'b0;  // Mispredict wins over a new entry
      end else if (redirect) begin
        btb_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (btb_en && redirect) begin
      btb_pc     <= branch_pc;
      btb_target <= pc_target;
    end
  end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top #(
  parameter int ICACHE_LINES = 8,
  parameter int LINE_WORDS   = 4
) (
  input  logic               clk,
  input  logic               reset,

  // Pipeline side
  input  logic               stall,
  input  brisc_pkg::pc_src_e pc_src,
  input  brisc_pkg::addr_t   pc_target,
  input  logic               xcpt,
  input  brisc_pkg::addr_t   branch_pc,
  input  logic               pred_wrong,
  output brisc_pkg::instr_t  instr,
  output brisc_pkg::addr_t   pc,
  output brisc_pkg::addr_t   pc_plus4,
  output logic               instr_valid,
  output logic               pred_taken,

  // Data port
  input  logic               dport_req,
  input  logic               dport_rw,
  input  brisc_pkg::addr_t   dport_addr,
  input  brisc_pkg::word_t   dport_wdata,
  output logic               dport_done,
  output brisc_pkg::word_t   dport_rdata,

  // Shared memory port
  output logic               mem_req,
  output logic               mem_rw,
  output brisc_pkg::addr_t   mem_addr,
  output brisc_pkg::word_t   mem_wdata,
  input  logic               mem_resp,
  input  brisc_pkg::word_t   mem_rdata
);

  brisc_pkg::addr_t  lookup_addr;
  logic              hit;
  brisc_pkg::instr_t hit_instr;
  logic              ic_req;
  brisc_pkg::addr_t  ic_addr;
  logic              ic_done;
  brisc_pkg::word_t  ic_rdata;

  fetch_stage u_fetch_stage (
    .clk         (clk),
    .reset       (reset),
    .stall       (stall),
    .pc_src      (pc_src),
    .xcpt        (xcpt),
    .pc_target   (pc_target),
    .branch_pc   (branch_pc),
    .pred_wrong  (pred_wrong),
    .hit         (hit),
    .hit_instr   (hit_instr),
    .lookup_addr (lookup_addr),
    .instr       (instr),
    .pc          (pc),
    .pc_plus4    (pc_plus4),
    .instr_valid (instr_valid),
    .pred_taken  (pred_taken)
  );

  icache #(
    .ICACHE_LINES (ICACHE_LINES),
    .LINE_WORDS   (LINE_WORDS)
  ) u_icache (
    .clk         (clk),
    .reset       (reset),
    .lookup_addr (lookup_addr),
    .ic_done     (ic_done),
    .ic_rdata    (ic_rdata),
    .hit         (hit),
    .hit_instr   (hit_instr),
    .ic_req      (ic_req),
    .ic_addr     (ic_addr)
  );

  mem_arbiter u_mem_arbiter (
    .clk         (clk),
    .reset       (reset),
    .dport_req   (dport_req),
    .dport_rw    (dport_rw),
    .dport_addr  (dport_addr),
    .dport_wdata (dport_wdata),
    .dport_done  (dport_done),
    .dport_rdata (dport_rdata),
    .ic_req      (ic_req),
    .ic_addr     (ic_addr),
    .ic_done     (ic_done),
    .ic_rdata    (ic_rdata),
    .mem_req     (mem_req),
    .mem_rw      (mem_rw),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .mem_resp    (mem_resp),
    .mem_rdata   (mem_rdata)
  );

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ns

module icache #(
  parameter int ICACHE_LINES = 8,
  parameter int LINE_WORDS   = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  brisc_pkg::addr_t  lookup_addr,
  input  logic              ic_done,
  input  brisc_pkg::word_t  ic_rdata,
  output logic              hit,
  output brisc_pkg::instr_t hit_instr,
  output logic              ic_req,
  output brisc_pkg::addr_t  ic_addr
);

  localparam int OFFSET_BITS = $clog2(LINE_WORDS);
  localparam int INDEX_BITS  = $clog2(ICACHE_LINES);
  localparam int TAG_BITS    = 32 - 2 - OFFSET_BITS - INDEX_BITS;
  localparam int LINE_LSB    = 2 + OFFSET_BITS;

  typedef logic [TAG_BITS-1:0]    tag_t;
  typedef logic [INDEX_BITS-1:0]  index_t;
  typedef logic [OFFSET_BITS-1:0] offset_t;

  tag_t                      tag_mem [ICACHE_LINES];
  logic [ICACHE_LINES-1:0]   line_valid;
  brisc_pkg::word_t          data_mem [ICACHE_LINES*LINE_WORDS];

  brisc_pkg::icache_state_e  state;
  brisc_pkg::addr_t          fill_base;
  offset_t                   fill_word;

  tag_t    look_tag;
  index_t  look_index;
  offset_t look_word;
  index_t  fill_index;
  logic    miss_start;
  logic    word_done;
  logic    last_word;

  assign look_tag   = lookup_addr[31 -: TAG_BITS];
  assign look_index = lookup_addr[LINE_LSB +: INDEX_BITS];
  assign look_word  = lookup_addr[2 +: OFFSET_BITS];
  assign fill_index = fill_base[LINE_LSB +: INDEX_BITS];

  assign hit       = line_valid[look_index] && (tag_mem[look_index] == look_tag);
  assign hit_instr = data_mem[{look_index, look_word}];

  assign miss_start = (state == brisc_pkg::IDLE) && !hit;
  assign word_done  = (state == brisc_pkg::REQ) && ic_done;
  assign last_word  = (fill_word == offset_t'(LINE_WORDS - 1));

  // Words of a line are fetched in ascending order
  assign ic_req  = (state == brisc_pkg::REQ);
  assign ic_addr = {fill_base[31:LINE_LSB], fill_word, 2'b00};

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= brisc_pkg::IDLE;
      line_valid <= '0;
      fill_word  <= '0;
    end else begin
      case (state)
        brisc_pkg::IDLE: begin
          if (miss_start) begin
            fill_base              <= {lookup_addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
            fill_word              <= '0;
            line_valid[look_index] <= 1'b0;  // Old contents are overwritten from here on
            state                  <= brisc_pkg::REQ;
          end
        end
        brisc_pkg::REQ: begin
          if (ic_done) begin
            fill_word <= fill_word + 1'b1;
            if (last_word) begin
              line_valid[fill_index] <= 1'b1;
              state                  <= brisc_pkg::IDLE;
            end else begin
              state <= brisc_pkg::WAIT;
            end
          end
        end
        brisc_pkg::WAIT: begin
          state <= brisc_pkg::REQ;  // Drops ic_req for a cycle so the port can switch owner
        end
        default: begin
          state <= brisc_pkg::IDLE;
        end
      endcase
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (miss_start) begin
      tag_mem[look_index] <= look_tag;
    end
    if (word_done) begin
      data_mem[{fill_index, fill_word}] <= ic_rdata;
    end
  end

endmodule

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter (
  input  logic             clk,
  input  logic             reset,
  input  logic             dport_req,
  input  logic             dport_rw,
  input  brisc_pkg::addr_t dport_addr,
  input  brisc_pkg::word_t dport_wdata,
  output logic             dport_done,
  output brisc_pkg::word_t dport_rdata,
  input  logic             ic_req,
  input  brisc_pkg::addr_t ic_addr,
  output logic             ic_done,
  output brisc_pkg::word_t ic_rdata,
  output logic             mem_req,
  output logic             mem_rw,
  output brisc_pkg::addr_t mem_addr,
  output brisc_pkg::word_t mem_wdata,
  input  logic             mem_resp,
  input  brisc_pkg::word_t mem_rdata
);

  logic busy;
  logic owner_dport;
  logic grant_dport;
  logic grant_ic;

  // A free port goes to the data side first
  always_comb begin
    if (busy) begin
      grant_dport = owner_dport;
      grant_ic    = ~owner_dport;
    end else begin
      grant_dport = dport_req;
      grant_ic    = ic_req & ~dport_req;
    end
  end

  assign mem_req   = grant_dport | grant_ic;
  assign mem_rw    = grant_dport & dport_rw;  // Instruction fetches only read
  assign mem_addr  = grant_dport ? dport_addr : ic_addr;
  assign mem_wdata = dport_wdata;

  assign dport_done  = mem_resp & grant_dport;
  assign ic_done     = mem_resp & grant_ic;
  assign dport_rdata = mem_rdata;
  assign ic_rdata    = mem_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy        <= 1'b0;
      owner_dport <= 1'b0;
    end else if (mem_resp) begin
      busy <= 1'b0;
    end else if (!busy && mem_req) begin
      busy        <= 1'b1;  // Lock the owner for the rest of the access
      owner_dport <= grant_dport;
    end
  end

endmodule

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;

  localparam int TIMEOUT_CYCLES = 4000;

  logic               clk;
  logic               reset;
  logic               stall;
  brisc_pkg::pc_src_e pc_src;
  brisc_pkg::addr_t   pc_target;
  logic               xcpt;
  brisc_pkg::addr_t   branch_pc;
  logic               pred_wrong;
  brisc_pkg::instr_t  instr;
  brisc_pkg::addr_t   pc;
  brisc_pkg::addr_t   pc_plus4;
  logic               instr_valid;
  logic               pred_taken;
  logic               dport_req;
  logic               dport_rw;
  brisc_pkg::addr_t   dport_addr;
  brisc_pkg::word_t   dport_wdata;
  logic               dport_done;
  brisc_pkg::word_t   dport_rdata;
  logic               mem_req;
  logic               mem_rw;
  brisc_pkg::addr_t   mem_addr;
  brisc_pkg::word_t   mem_wdata;
  logic               mem_resp;
  brisc_pkg::word_t   mem_rdata;

  brisc_pkg::word_t   mem [256];
  brisc_pkg::addr_t   exp_pc;
  logic               resp_wait;
  int                 errors;
  int                 cycle_count;

  fetch_top UUT (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Memory answers on the second edge after it first sees a request
  always @(posedge clk) begin
    if (reset || mem_resp) begin
      mem_resp  <= 1'b0;
      resp_wait <= 1'b0;
    end else if (mem_req) begin
      if (resp_wait) begin
        mem_resp  <= 1'b1;
        mem_rdata <= mem[mem_addr[9:2]];
        if (mem_rw) begin
          mem[mem_addr[9:2]] <= mem_wdata;
        end
      end else begin
        resp_wait <= 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test FAILED");
      $finish;
    end
  end

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_valid();
    while (!instr_valid) begin
      tick();
    end
  endtask

  task automatic check_addr(input string name, input brisc_pkg::addr_t expected,
                            input brisc_pkg::addr_t actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_instr(input string name, input brisc_pkg::instr_t expected,
                             input brisc_pkg::instr_t actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_word(input string name, input brisc_pkg::word_t expected,
                            input brisc_pkg::word_t actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // Steps sequentially from exp_pc and stops on the valid cycle at stop_pc
  task automatic run_until(input string name, input brisc_pkg::addr_t stop_pc);
    logic done;
    done = 1'b0;
    while (!done) begin
      wait_valid();
      check_addr(name, exp_pc, pc);
      check_addr(name, exp_pc + 32'd4, pc_plus4);
      check_instr(name, mem[exp_pc[9:2]], instr);
      if (exp_pc == stop_pc) begin
        done = 1'b1;
      end else begin
        check_bit(name, 1'b0, pred_taken);
        tick();
        exp_pc = exp_pc + 32'd4;
      end
    end
  endtask

  task automatic redirect(input brisc_pkg::addr_t target, input brisc_pkg::addr_t branch);
    pc_src    = brisc_pkg::PC_ALU;
    pc_target = target;
    branch_pc = branch;
    tick();
    pc_src = brisc_pkg::PC_SEQ;
    exp_pc = target;
  endtask

  task automatic data_access(input logic rw, input brisc_pkg::addr_t addr,
                             input brisc_pkg::word_t wdata, output brisc_pkg::word_t rdata);
    dport_req   = 1'b1;
    dport_rw    = rw;
    dport_addr  = addr;
    dport_wdata = wdata;
    while (!dport_done) begin
      tick();
    end
    rdata     = dport_rdata;
    dport_req = 1'b0;
  endtask

  task automatic reset_state();
    check_addr("reset_state", brisc_pkg::PC_BOOT, pc);
    check_bit("reset_state", 1'b0, instr_valid);
    check_bit("reset_state", 1'b0, pred_taken);
    check_bit("reset_state", 1'b0, mem_req);
  endtask

  task automatic sequential_fetch();
    exp_pc = brisc_pkg::PC_BOOT;
    run_until("sequential_fetch", 32'h18);  // Second line refills at 0x10
    stall = 1'b1;
    tick();
    tick();
    check_addr("sequential_fetch", exp_pc, pc);
    check_instr("sequential_fetch", mem[exp_pc[9:2]], instr);
    stall = 1'b0;
  endtask

  task automatic redirect_and_predict();
    redirect(32'h80, 32'h2C);
    check_addr("redirect_and_predict", 32'h80, pc);
    redirect(32'h40, 32'h48);  // BTB now maps 0x48 back to 0x40
    check_addr("redirect_and_predict", 32'h40, pc);
    run_until("redirect_and_predict", 32'h48);
    check_bit("redirect_and_predict", 1'b1, pred_taken);
    tick();
    exp_pc = 32'h40;
    check_addr("redirect_and_predict", exp_pc, pc);
  endtask

  task automatic mispredict_clear();
    wait_valid();
    pred_wrong = 1'b1;
    tick();
    pred_wrong = 1'b0;
    exp_pc     = exp_pc + 32'd4;
    run_until("mispredict_clear", 32'h48);
    check_bit("mispredict_clear", 1'b0, pred_taken);
    tick();
    check_addr("mispredict_clear", 32'h4C, pc);
  endtask

  task automatic exception();
    stall = 1'b1;
    xcpt  = 1'b1;
    tick();
    xcpt = 1'b0;
    check_addr("exception", brisc_pkg::PC_XCPT, pc);
    stall  = 1'b0;
    exp_pc = brisc_pkg::PC_XCPT;
    run_until("exception", brisc_pkg::PC_XCPT);
  endtask

  task automatic data_port();
    brisc_pkg::word_t rdata;
    logic             dport_seen;
    data_access(1'b1, 32'h3F0, 32'h5EED_0043, rdata);
    tick();
    check_word("data_port", 32'h5EED_0043, mem[8'hFC]);
    data_access(1'b0, 32'h3F0, '0, rdata);
    check_word("data_port", 32'h5EED_0043, rdata);
    tick();
    wait_valid();
    redirect(32'h200, 32'h3FC);
    check_bit("data_port", 1'b0, instr_valid);
    dport_req  = 1'b1;  // Same cycle as the miss at 0x200
    dport_rw   = 1'b0;
    dport_addr = 32'h3F0;
    dport_seen = 1'b0;
    while (!instr_valid) begin
      tick();
      if (dport_done && !dport_seen) begin
        dport_seen = 1'b1;
        check_word("data_port", 32'h5EED_0043, dport_rdata);
        dport_req = 1'b0;
      end
    end
    check_bit("data_port", 1'b1, dport_seen);
    run_until("data_port", 32'h200);
  endtask

  initial begin
    logic [31:0] rng;
    rng = 32'd67;
    for (int i = 0; i < 256; i++) begin
      rng    = xorshift(rng);
      mem[i] = rng;
    end
    errors      = 0;
    cycle_count = 0;
    reset       = 1'b1;
    stall       = 1'b0;
    pc_src      = brisc_pkg::PC_SEQ;
    pc_target   = '0;
    xcpt        = 1'b0;
    branch_pc   = '0;
    pred_wrong  = 1'b0;
    dport_req   = 1'b0;
    dport_rw    = 1'b0;
    dport_addr  = '0;
    dport_wdata = '0;
    mem_resp    = 1'b0;
    mem_rdata   = '0;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;

    reset_state();
    sequential_fetch();
    redirect_and_predict();
    mispredict_clear();
    exception();
    data_port();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
src/brisc_pkg.sv
src/fetch_stage.sv
src/icache.sv
src/mem_arbiter.sv
src/fetch_top.sv
testbench/fetch_tb.sv
